// File: files.f
hw/wb_pkg.sv
hw/reg_file.sv
hw/csr_file.sv
hw/wb_stage.sv
hw/wb_top.sv
test/tb_wb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_wb_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_top;

    localparam int TLB_NUM = 16;
    localparam int IDXW    = $clog2(TLB_NUM);
    localparam int PERIOD  = 40;
    localparam int unsigned SEED = 32'hec65_04b9;

    typedef enum logic [2:0] {K_IDLE, K_ALU, K_CSR, K_TID, K_EX, K_ERTN, K_TLB} kind_t;

    // one memory-stage item laid out like the mem_* ports
    typedef struct packed {
        logic                valid, rf_we, read_tid, csr_re, csr_we, ertn, excep;
        logic                conflict, found;
        wb_pkg::word_t       pc, wdata, wmask, wvalue, badv;
        wb_pkg::reg_addr_t   waddr;
        wb_pkg::csr_num_t    csr_num;
        wb_pkg::ecode_t      ecode;
        wb_pkg::esubcode_t   esub;
        wb_pkg::tlb_op_t     tlb_op;
        logic [IDXW-1:0]     idx;
    } row_t;

    // model slots with 9 for any unimplemented number
    localparam int S_CRMD = 0, S_PRMD = 1, S_ESTAT = 2, S_ERA = 3, S_BADV = 4;
    localparam int S_EENTRY = 5, S_TLBIDX = 6, S_TID = 7, S_TLBRENTRY = 8;
    localparam wb_pkg::csr_num_t NUMS [0:8] = '{wb_pkg::CSR_CRMD, wb_pkg::CSR_PRMD,
        wb_pkg::CSR_ESTAT, wb_pkg::CSR_ERA, wb_pkg::CSR_BADV, wb_pkg::CSR_EENTRY,
        wb_pkg::CSR_TLBIDX, wb_pkg::CSR_TID, wb_pkg::CSR_TLBRENTRY};
    localparam wb_pkg::word_t WBITS [0:9] = '{32'h1ff, 32'h7, 32'h3, 32'hffff_ffff,
        32'hffff_ffff, 32'hffff_ffc0, 32'hbf00_0000 | (2**IDXW - 1), 32'hffff_ffff,
        32'hffff_ffc0, 32'h0};

    logic                clk, resetn, built;
    wb_pkg::reg_addr_t   raddr1, raddr2;
    logic                wb_allowin, wb_to_ex_conflict, wb_ex, ertn_flush, tlbsrch_en;
    logic                tlbsrch_found, tlb_wr, tlb_fill, tlb_rd, refetch_flush, wb_fwd_we;
    logic [3:0]          debug_wb_rf_we;
    logic [IDXW-1:0]     tlbsrch_idx;
    wb_pkg::ecode_t      ex_ecode;
    wb_pkg::esubcode_t   ex_esubcode;
    wb_pkg::reg_addr_t   debug_wb_rf_wnum, wb_fwd_waddr;
    wb_pkg::word_t       ex_pc, ex_badv, flush_entry, debug_wb_pc, debug_wb_rf_wdata;
    wb_pkg::word_t       rdata1, rdata2, wb_fwd_wdata;
    row_t                rows [$];
    row_t                cur;                // item on the mem_* inputs
    wb_pkg::word_t       m_csr [0:9];
    wb_pkg::word_t       m_regs [0:31];
    int                  errors;

    wb_top #(.TLB_NUM(TLB_NUM)) dut0 (
        .mem_valid(cur.valid), .mem_pc(cur.pc), .mem_rf_we(cur.rf_we),
        .mem_rf_waddr(cur.waddr), .mem_rf_wdata(cur.wdata), .mem_read_tid(cur.read_tid),
        .mem_csr_re(cur.csr_re), .mem_csr_we(cur.csr_we), .mem_csr_num(cur.csr_num),
        .mem_csr_wmask(cur.wmask), .mem_csr_wvalue(cur.wvalue), .mem_ertn(cur.ertn),
        .mem_excep(cur.excep), .mem_ecode(cur.ecode), .mem_esubcode(cur.esub),
        .mem_badv(cur.badv), .mem_tlb_op(cur.tlb_op), .mem_srch_conflict(cur.conflict),
        .mem_tlbsrch_found(cur.found), .mem_tlbsrch_idx(cur.idx),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (built);
        #((rows.size() + 20) * PERIOD);
        $display("timeout: the stimulus table did not finish in time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report(input string name, input wb_pkg::word_t got, input wb_pkg::word_t exp);
        errors++;
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        $display("Verification failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input wb_pkg::word_t got,
                              input wb_pkg::word_t exp);
        if (got !== exp) report(name, got, exp);
    endtask

    task automatic check_addr(input string name, input wb_pkg::reg_addr_t got,
                              input wb_pkg::reg_addr_t exp);
        if (got !== exp) report(name, {27'd0, got}, {27'd0, exp});
    endtask

    task automatic check_ecode(input string name, input wb_pkg::ecode_t got,
                               input wb_pkg::ecode_t exp);
        if (got !== exp) report(name, {26'd0, got}, {26'd0, exp});
    endtask

    task automatic check_esub(input string name, input wb_pkg::esubcode_t got,
                              input wb_pkg::esubcode_t exp);
        if (got !== exp) report(name, {23'd0, got}, {23'd0, exp});
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report(name, {31'd0, got}, {31'd0, exp});
    endtask

    function automatic int slot(input wb_pkg::csr_num_t num);
        for (int k = 0; k < 9; k++) begin
            if (NUMS[k] == num) return k;
        end
        return 9;
    endfunction

    function automatic row_t make(input kind_t kind, input int rd, input wb_pkg::csr_num_t num,
                                  input int arg);
        row_t r;
        r         = '0;
        r.valid   = (kind != K_IDLE);
        r.pc      = $urandom & 32'hffff_fffc;
        r.waddr   = 5'(rd);
        r.wdata   = $urandom;
        r.csr_num = num;
        r.wvalue  = $urandom;
        r.wmask   = (arg == 1) ? 32'hffff_ffff : $urandom;   // arg 1 gives a full mask
        r.badv    = $urandom;
        r.esub    = 9'($urandom);
        r.idx     = IDXW'($urandom);
        case (kind)
            K_ALU:  r.rf_we = 1'b1;
            K_CSR:  {r.rf_we, r.csr_re, r.csr_we} = {2'b11, arg != 0};
            K_TID:  {r.rf_we, r.read_tid} = 2'b11;
            K_EX:   {r.rf_we, r.excep, r.ecode} = {2'b11, 6'(arg)};
            K_ERTN: r.ertn = 1'b1;
            K_TLB:  {r.conflict, r.found, r.tlb_op} = 7'(arg);   // conflict bit 6 and found bit 5
            default: begin
                {r.rf_we, r.ertn, r.excep, r.conflict} = 4'hf;   // must stay hidden
                r.tlb_op = '1;
            end
        endcase
        return r;
    endfunction

    // every fourth row is a bubble
    task automatic add(input row_t r);
        rows.push_back(r);
        if (rows.size() % 4 == 3) rows.push_back(make(K_IDLE, 0, '0, 0));
    endtask

    task automatic add_reads(input int rd);
        for (int k = 0; k < 9; k++) add(make(K_CSR, rd + k, NUMS[k], 0));
    endtask

    function automatic wb_pkg::word_t exp_wdata(input row_t r);
        if (r.csr_re) return m_csr[slot(r.csr_num)];
        return r.read_tid ? m_csr[S_TID] : r.wdata;
    endfunction

    task automatic check_row(input row_t r);
        logic          we;
        wb_pkg::word_t entry;
        we    = r.valid & r.rf_we & ~r.excep;
        entry = r.excep ? ((r.ecode == wb_pkg::ECODE_TLBR) ? m_csr[S_TLBRENTRY] : m_csr[S_EENTRY])
              : r.ertn ? m_csr[S_ERA] : r.pc + 32'd4;
        check_bit("wb_allowin", wb_allowin, 1'b1);
        check_bit("wb_fwd_we", wb_fwd_we, we);
        check_word("debug_wb_rf_we", {28'd0, debug_wb_rf_we}, we ? 32'hf : 32'h0);
        check_bit("wb_ex", wb_ex, r.valid & r.excep);
        check_bit("ertn_flush", ertn_flush, r.valid & r.ertn);
        check_bit("refetch_flush", refetch_flush, r.valid & (|r.tlb_op[3:0]));
        check_bit("tlbsrch_en", tlbsrch_en, r.valid & r.tlb_op[4]);
        check_bit("tlb_wr", tlb_wr, r.valid & r.tlb_op[3]);
        check_bit("tlb_fill", tlb_fill, r.valid & r.tlb_op[2]);
        check_bit("tlb_rd", tlb_rd, r.valid & r.tlb_op[1]);
        check_bit("wb_to_ex_conflict", wb_to_ex_conflict, r.valid & r.conflict);
        if (r.valid) begin
            check_word("debug_wb_pc", debug_wb_pc, r.pc);
            check_word("flush_entry", flush_entry, entry);
            if (r.excep) begin
                check_ecode("ex_ecode", ex_ecode, r.ecode);
                check_esub("ex_esubcode", ex_esubcode, r.esub);
                check_word("ex_pc", ex_pc, r.pc);
                check_word("ex_badv", ex_badv, r.badv);
            end
            if (r.tlb_op[4]) begin
                check_bit("tlbsrch_found", tlbsrch_found, r.found);
                check_word("tlbsrch_idx", 32'(tlbsrch_idx), 32'(r.idx));
            end
        end
        if (we) begin
            check_addr("debug_wb_rf_wnum", debug_wb_rf_wnum, r.waddr);
            check_addr("wb_fwd_waddr", wb_fwd_waddr, r.waddr);
            check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata(r));
            check_word("wb_fwd_wdata", wb_fwd_wdata, exp_wdata(r));
        end
    endtask

    // reference model update for the edge after the check
    task automatic apply_row(input row_t r);
        wb_pkg::word_t wd;
        wb_pkg::word_t m;
        int            s;
        wd = exp_wdata(r);
        s  = slot(r.csr_num);
        m  = r.wmask & WBITS[s];
        if (!r.valid) return;
        if (r.rf_we && !r.excep && r.waddr != 5'd0) m_regs[r.waddr] = wd;
        if (r.csr_we && !r.excep) m_csr[s] = (m_csr[s] & ~m) | (r.wvalue & m);
        if (r.excep) begin
            m_csr[S_PRMD][2:0]    = m_csr[S_CRMD][2:0];   // plv and ie
            m_csr[S_CRMD][2:0]    = 3'b000;
            m_csr[S_ESTAT][30:16] = {r.esub, r.ecode};
            m_csr[S_ERA]          = r.pc;
            if (r.ecode == wb_pkg::ECODE_TLBR) m_csr[S_CRMD][3] = 1'b1;
            if (r.ecode inside {wb_pkg::ECODE_ADE, wb_pkg::ECODE_ALE, wb_pkg::ECODE_PIL,
                                wb_pkg::ECODE_PIS, wb_pkg::ECODE_PIF, wb_pkg::ECODE_PME,
                                wb_pkg::ECODE_PPI}) m_csr[S_BADV] = r.badv;
        end
        if (r.ertn) begin
            m_csr[S_CRMD][2:0] = m_csr[S_PRMD][2:0];
            if (m_csr[S_ESTAT][21:16] == wb_pkg::ECODE_TLBR) m_csr[S_CRMD][3] = 1'b0;
        end
        if (r.tlb_op[4]) begin
            if (r.found) m_csr[S_TLBIDX][IDXW-1:0] = r.idx;
            m_csr[S_TLBIDX][wb_pkg::TLBIDX_NE_BIT] = ~r.found;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        {built, resetn, raddr1, raddr2, errors} = '0;
        cur = '0;
        foreach (m_csr[k]) m_csr[k] = '0;
        foreach (m_regs[k]) m_regs[k] = '0;
        m_csr[S_CRMD] = 32'h8;   // da set after reset
        add(make(K_CSR, 1, wb_pkg::CSR_CRMD, 0));
        for (int k = 0; k < 4; k++) add(make(K_ALU, k, '0, 0));   // r0 included
        add(make(K_CSR, 4, wb_pkg::CSR_EENTRY, 1));
        add(make(K_CSR, 5, wb_pkg::CSR_TLBRENTRY, 1));
        add(make(K_CSR, 6, wb_pkg::CSR_TID, 2));
        add(make(K_TID, 7, '0, 0));
        add(make(K_CSR, 8, wb_pkg::CSR_CRMD, 2));
        add(make(K_CSR, 9, wb_pkg::CSR_PRMD, 2));
        add(make(K_CSR, 10, wb_pkg::CSR_ESTAT, 2));
        add(make(K_CSR, 11, wb_pkg::CSR_TLBIDX, 2));
        add(make(K_CSR, 12, 14'h3ff, 0));   // not implemented
        add_reads(20);
        add(make(K_EX, 13, '0, int'(wb_pkg::ECODE_ADE)));
        add_reads(20);
        add(make(K_ERTN, 0, '0, 0));
        add(make(K_CSR, 14, wb_pkg::CSR_CRMD, 0));
        add(make(K_EX, 15, '0, int'(wb_pkg::ECODE_TLBR)));
        add_reads(20);
        add(make(K_ERTN, 0, '0, 0));
        add(make(K_CSR, 16, wb_pkg::CSR_CRMD, 0));
        add(make(K_EX, 17, '0, 'hb));   // syscall leaves badv untouched
        add_reads(20);
        foreach (NUMS[k]) add(make(K_TLB, 0, '0, (k < 4) ? ('h08 >> k) | 'h40 : 'h70 - k[0]));
        add(make(K_CSR, 18, wb_pkg::CSR_TLBIDX, 0));
        add(make(K_TLB, 0, '0, 'h10));   // tlbsrch miss
        add(make(K_CSR, 19, wb_pkg::CSR_TLBIDX, 0));
        rows.push_back(make(K_IDLE, 0, '0, 0));
        rows.push_back(make(K_IDLE, 0, '0, 0));
        built = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;
        check_row('0);
        foreach (rows[i]) begin
            cur = rows[i];
            @(posedge clk);
            #2;
            check_word("rdata1", rdata1, m_regs[raddr1]);
            check_word("rdata2", rdata2, m_regs[raddr2]);
            check_row(rows[i]);
            apply_row(rows[i]);
            if (rows[i].valid && rows[i].rf_we && !rows[i].excep) begin
                raddr2 = raddr1;
                raddr1 = rows[i].waddr;
            end
        end
        if (errors == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// File: hw/wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_top #(
    parameter int TLB_NUM = 16
) (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         mem_valid,
    input  wb_pkg::word_t               mem_pc,
    input  wire                         mem_rf_we,
    input  wb_pkg::reg_addr_t           mem_rf_waddr,
    input  wb_pkg::word_t               mem_rf_wdata,
    input  wire                         mem_read_tid,
    input  wire                         mem_csr_re,
    input  wire                         mem_csr_we,
    input  wb_pkg::csr_num_t            mem_csr_num,
    input  wb_pkg::word_t               mem_csr_wmask,
    input  wb_pkg::word_t               mem_csr_wvalue,
    input  wire                         mem_ertn,
    input  wire                         mem_excep,
    input  wb_pkg::ecode_t              mem_ecode,
    input  wb_pkg::esubcode_t           mem_esubcode,
    input  wb_pkg::word_t               mem_badv,
    input  wb_pkg::tlb_op_t             mem_tlb_op,
    input  wire                         mem_srch_conflict,
    input  wire                         mem_tlbsrch_found,
    input  wire [$clog2(TLB_NUM)-1:0]   mem_tlbsrch_idx,
    output wire                         wb_allowin,
    output wire                         wb_to_ex_conflict,
    output wire                         wb_ex,
    output wire                         ertn_flush,
    output wb_pkg::ecode_t              ex_ecode,
    output wb_pkg::esubcode_t           ex_esubcode,
    output wb_pkg::word_t               ex_pc,
    output wb_pkg::word_t               ex_badv,
    output wire                         tlbsrch_en,
    output wire                         tlbsrch_found,
    output wire [$clog2(TLB_NUM)-1:0]   tlbsrch_idx,
    output wire                         tlb_wr,
    output wire                         tlb_fill,
    output wire                         tlb_rd,
    output wire                         refetch_flush,
    output wb_pkg::word_t               flush_entry,
    output wb_pkg::word_t               debug_wb_pc,
    output wire [3:0]                   debug_wb_rf_we,
    output wb_pkg::reg_addr_t           debug_wb_rf_wnum,
    output wb_pkg::word_t               debug_wb_rf_wdata,
    // decode read ports and forward path
    input  wb_pkg::reg_addr_t           raddr1,
    input  wb_pkg::reg_addr_t           raddr2,
    output wb_pkg::word_t               rdata1,
    output wb_pkg::word_t               rdata2,
    output wire                         wb_fwd_we,
    output wb_pkg::reg_addr_t           wb_fwd_waddr,
    output wb_pkg::word_t               wb_fwd_wdata
);

    wire              csr_re;
    wb_pkg::csr_num_t csr_num;
    wire              csr_we;
    wb_pkg::word_t    csr_wmask;
    wb_pkg::word_t    csr_wvalue;
    wb_pkg::word_t    csr_rvalue;

    // the forward path is the register write itself
    wb_stage #(.TLB_NUM(TLB_NUM)) wb_stage0 (
        .clk, .resetn,
        .mem_valid, .mem_pc, .mem_rf_we, .mem_rf_waddr, .mem_rf_wdata, .mem_read_tid,
        .mem_csr_re, .mem_csr_we, .mem_csr_num, .mem_csr_wmask, .mem_csr_wvalue,
        .mem_ertn, .mem_excep, .mem_ecode, .mem_esubcode, .mem_badv, .mem_tlb_op,
        .mem_srch_conflict, .mem_tlbsrch_found, .mem_tlbsrch_idx,
        .csr_rvalue, .wb_allowin,
        .rf_we(wb_fwd_we), .rf_waddr(wb_fwd_waddr), .rf_wdata(wb_fwd_wdata),
        .wb_to_ex_conflict,
        .csr_re, .csr_num, .csr_we, .csr_wmask, .csr_wvalue,
        .wb_ex, .ertn_flush, .ex_ecode, .ex_esubcode, .ex_pc, .ex_badv,
        .tlbsrch_en, .tlbsrch_found, .tlbsrch_idx, .tlb_wr, .tlb_fill, .tlb_rd,
        .refetch_flush, .flush_entry,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    csr_file #(.TLB_NUM(TLB_NUM)) csr_file0 (
        .clk, .resetn,
        .csr_re, .csr_num, .csr_we, .csr_wmask, .csr_wvalue,
        .wb_ex, .ertn_flush, .ex_ecode, .ex_esubcode, .ex_pc, .ex_badv,
        .tlbsrch_en, .tlbsrch_found, .tlbsrch_idx,
        .csr_rvalue
    );

    reg_file reg_file0 (
        .clk,
        .we(wb_fwd_we), .waddr(wb_fwd_waddr), .wdata(wb_fwd_wdata),
        .raddr1, .raddr2, .rdata1, .rdata2
    );

endmodule

`default_nettype wire

// File: hw/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage #(
    parameter int TLB_NUM = 16
) (
    input  wire                         clk,
    input  wire                         resetn,
    // from memory stage
    input  wire                         mem_valid,
    input  wb_pkg::word_t               mem_pc,
    input  wire                         mem_rf_we,
    input  wb_pkg::reg_addr_t           mem_rf_waddr,
    input  wb_pkg::word_t               mem_rf_wdata,
    input  wire                         mem_read_tid,
    input  wire                         mem_csr_re,
    input  wire                         mem_csr_we,
    input  wb_pkg::csr_num_t            mem_csr_num,
    input  wb_pkg::word_t               mem_csr_wmask,
    input  wb_pkg::word_t               mem_csr_wvalue,
    input  wire                         mem_ertn,
    input  wire                         mem_excep,
    input  wb_pkg::ecode_t              mem_ecode,
    input  wb_pkg::esubcode_t           mem_esubcode,
    input  wb_pkg::word_t               mem_badv,
    input  wb_pkg::tlb_op_t             mem_tlb_op,
    input  wire                         mem_srch_conflict,
    input  wire                         mem_tlbsrch_found,
    input  wire [$clog2(TLB_NUM)-1:0]   mem_tlbsrch_idx,
    input  wb_pkg::word_t               csr_rvalue,
    output wire                         wb_allowin,
    // register file write, also forwarded to decode
    output wire                         rf_we,
    output wb_pkg::reg_addr_t           rf_waddr,
    output wb_pkg::word_t               rf_wdata,
    output wire                         wb_to_ex_conflict,
    // csr request
    output wire                         csr_re,
    output wb_pkg::csr_num_t            csr_num,
    output wire                         csr_we,
    output wb_pkg::word_t               csr_wmask,
    output wb_pkg::word_t               csr_wvalue,
    // exception / ertn / tlb events
    output wire                         wb_ex,
    output wire                         ertn_flush,
    output wb_pkg::ecode_t              ex_ecode,
    output wb_pkg::esubcode_t           ex_esubcode,
    output wb_pkg::word_t               ex_pc,
    output wb_pkg::word_t               ex_badv,
    output wire                         tlbsrch_en,
    output wire                         tlbsrch_found,
    output wire [$clog2(TLB_NUM)-1:0]   tlbsrch_idx,
    output wire                         tlb_wr,
    output wire                         tlb_fill,
    output wire                         tlb_rd,
    output wire                         refetch_flush,
    output wb_pkg::word_t               flush_entry,
    // trace
    output wb_pkg::word_t               debug_wb_pc,
    output wire [3:0]                   debug_wb_rf_we,
    output wb_pkg::reg_addr_t           debug_wb_rf_wnum,
    output wb_pkg::word_t               debug_wb_rf_wdata
);

    logic                       wb_valid;
    wb_pkg::word_t              wb_pc;
    logic                       wb_rf_we;
    wb_pkg::reg_addr_t          wb_rf_waddr;
    wb_pkg::word_t              wb_rf_wdata;
    logic                       wb_read_tid;
    logic                       wb_csr_re;
    logic                       wb_csr_we;
    wb_pkg::csr_num_t           wb_csr_num;
    wb_pkg::word_t              wb_csr_wmask;
    wb_pkg::word_t              wb_csr_wvalue;
    logic                       wb_ertn;
    logic                       wb_excep;
    wb_pkg::ecode_t             wb_ecode;
    wb_pkg::esubcode_t          wb_esubcode;
    wb_pkg::word_t              wb_badv;
    wb_pkg::tlb_op_t            wb_tlb_op;
    logic                       wb_srch_conflict;
    logic                       wb_srch_found;
    logic [$clog2(TLB_NUM)-1:0] wb_srch_idx;
    wb_pkg::word_t              final_wdata;

    assign wb_allowin = 1'b1;   // writeback never stalls

    // an ex/ertn item drops out unless a new one replaces it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_pc            <= mem_pc;
            wb_rf_we         <= mem_rf_we;
            wb_rf_waddr      <= mem_rf_waddr;
            wb_rf_wdata      <= mem_rf_wdata;
            wb_read_tid      <= mem_read_tid;
            wb_csr_re        <= mem_csr_re;
            wb_csr_we        <= mem_csr_we;
            wb_csr_num       <= mem_csr_num;
            wb_csr_wmask     <= mem_csr_wmask;
            wb_csr_wvalue    <= mem_csr_wvalue;
            wb_ertn          <= mem_ertn;
            wb_excep         <= mem_excep;
            wb_ecode         <= mem_ecode;
            wb_esubcode      <= mem_esubcode;
            wb_badv          <= mem_badv;
            wb_tlb_op        <= mem_tlb_op;
            wb_srch_conflict <= mem_srch_conflict;
            wb_srch_found    <= mem_tlbsrch_found;
            wb_srch_idx      <= mem_tlbsrch_idx;
        end
    end

    assign wb_ex      = wb_valid & wb_excep;
    assign ertn_flush = wb_valid & wb_ertn;

    // csrrd and rdcntid both take the csr read data
    assign final_wdata = (wb_csr_re | wb_read_tid) ? csr_rvalue : wb_rf_wdata;

    assign rf_we    = wb_valid & wb_rf_we & ~wb_excep;
    assign rf_waddr = wb_rf_waddr;
    assign rf_wdata = final_wdata;

    assign wb_to_ex_conflict = wb_valid & wb_srch_conflict;

    // exception entry and ertn steal the csr read port for the target
    assign csr_re  = wb_valid & (wb_csr_re | wb_read_tid | wb_excep | wb_ertn);
    assign csr_num = wb_ex       ? ((wb_ecode == wb_pkg::ECODE_TLBR) ? wb_pkg::CSR_TLBRENTRY
                                                                     : wb_pkg::CSR_EENTRY)
                   : ertn_flush  ? wb_pkg::CSR_ERA
                   : wb_read_tid ? wb_pkg::CSR_TID
                   : wb_csr_num;
    assign csr_we     = wb_valid & wb_csr_we & ~wb_excep;
    assign csr_wmask  = wb_csr_wmask;
    assign csr_wvalue = wb_csr_wvalue;

    assign ex_ecode    = wb_ecode;
    assign ex_esubcode = wb_esubcode;
    assign ex_pc       = wb_pc;
    assign ex_badv     = wb_badv;

    assign tlbsrch_en    = wb_valid & wb_tlb_op[4];
    assign tlbsrch_found = wb_srch_found;
    assign tlbsrch_idx   = wb_srch_idx;
    assign tlb_wr        = wb_valid & wb_tlb_op[3];
    assign tlb_fill      = wb_valid & wb_tlb_op[2];
    assign tlb_rd        = wb_valid & wb_tlb_op[1];

    // tlb changes the mapping, refetch from the next pc (invtlb included)
    assign refetch_flush = wb_valid & (|wb_tlb_op[3:0]);
    assign flush_entry   = (wb_ex | ertn_flush) ? csr_rvalue : wb_pc + 32'd4;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_rf_waddr;
    assign debug_wb_rf_wdata = final_wdata;

endmodule

`default_nettype wire

// File: hw/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter int TLB_NUM = 16
) (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         csr_re,
    input  wb_pkg::csr_num_t            csr_num,
    input  wire                         csr_we,
    input  wb_pkg::word_t               csr_wmask,
    input  wb_pkg::word_t               csr_wvalue,
    input  wire                         wb_ex,
    input  wire                         ertn_flush,
    input  wb_pkg::ecode_t              ex_ecode,
    input  wb_pkg::esubcode_t           ex_esubcode,
    input  wb_pkg::word_t               ex_pc,
    input  wb_pkg::word_t               ex_badv,
    input  wire                         tlbsrch_en,
    input  wire                         tlbsrch_found,
    input  wire [$clog2(TLB_NUM)-1:0]   tlbsrch_idx,
    output wb_pkg::word_t               csr_rvalue
);

    localparam int IDXW = $clog2(TLB_NUM);

    // bits that software may change per csr
    localparam wb_pkg::word_t CRMD_WBITS   = 32'h0000_01ff;
    localparam wb_pkg::word_t PRMD_WBITS   = 32'h0000_0007;
    localparam wb_pkg::word_t ESTAT_WBITS  = 32'h0000_0003;  // swi only
    localparam wb_pkg::word_t ENTRY_WBITS  = 32'hffff_ffc0;  // 64-byte aligned
    localparam wb_pkg::word_t TLBIDX_WBITS = 32'hbf00_0000 | ((32'd1 << IDXW) - 32'd1);

    wb_pkg::word_t crmd;
    wb_pkg::word_t prmd;
    wb_pkg::word_t estat;
    wb_pkg::word_t era;
    wb_pkg::word_t badv;
    wb_pkg::word_t eentry;
    wb_pkg::word_t tlbidx;
    wb_pkg::word_t tid;
    wb_pkg::word_t tlbrentry;
    wb_pkg::word_t rd_value;
    logic          badv_load;

    // masked write of the current request into old_v
    function automatic wb_pkg::word_t merge(input wb_pkg::word_t old_v,
                                            input wb_pkg::word_t wbits);
        wb_pkg::word_t m;
        m = csr_wmask & wbits;
        return (old_v & ~m) | (csr_wvalue & m);
    endfunction

    // address-type exceptions carry a bad virtual address
    assign badv_load = ex_ecode inside {wb_pkg::ECODE_ADE, wb_pkg::ECODE_ALE,
                                        wb_pkg::ECODE_PIL, wb_pkg::ECODE_PIS,
                                        wb_pkg::ECODE_PIF, wb_pkg::ECODE_PME,
                                        wb_pkg::ECODE_PPI};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd      <= 32'h0000_0008;   // da=1, plv0, ie off
            prmd      <= 32'd0;
            estat     <= 32'd0;
            era       <= 32'd0;
            badv      <= 32'd0;
            eentry    <= 32'd0;
            tlbidx    <= 32'd0;
            tid       <= 32'd0;
            tlbrentry <= 32'd0;
        end else begin
            if (csr_we) begin
                case (csr_num)
                    wb_pkg::CSR_CRMD:      crmd      <= merge(crmd, CRMD_WBITS);
                    wb_pkg::CSR_PRMD:      prmd      <= merge(prmd, PRMD_WBITS);
                    wb_pkg::CSR_ESTAT:     estat     <= merge(estat, ESTAT_WBITS);
                    wb_pkg::CSR_ERA:       era       <= merge(era, 32'hffff_ffff);
                    wb_pkg::CSR_BADV:      badv      <= merge(badv, 32'hffff_ffff);
                    wb_pkg::CSR_EENTRY:    eentry    <= merge(eentry, ENTRY_WBITS);
                    wb_pkg::CSR_TLBIDX:    tlbidx    <= merge(tlbidx, TLBIDX_WBITS);
                    wb_pkg::CSR_TID:       tid       <= merge(tid, 32'hffff_ffff);
                    wb_pkg::CSR_TLBRENTRY: tlbrentry <= merge(tlbrentry, ENTRY_WBITS);
                    default: ;
                endcase
            end
            if (wb_ex) begin
                // save mode, then drop to plv0 with interrupts off
                prmd[wb_pkg::CRMD_PLV_LSB +: 2] <= crmd[wb_pkg::CRMD_PLV_LSB +: 2];
                prmd[wb_pkg::CRMD_IE_BIT]       <= crmd[wb_pkg::CRMD_IE_BIT];
                crmd[wb_pkg::CRMD_PLV_LSB +: 2] <= 2'b00;
                crmd[wb_pkg::CRMD_IE_BIT]       <= 1'b0;
                if (ex_ecode == wb_pkg::ECODE_TLBR) begin
                    crmd[wb_pkg::CRMD_DA_BIT] <= 1'b1;   // refill runs untranslated
                end
                estat[wb_pkg::ESTAT_ECODE_LSB +: 6] <= ex_ecode;
                estat[wb_pkg::ESTAT_ESUB_LSB +: 9]  <= ex_esubcode;
                era <= ex_pc;
                if (badv_load) begin
                    badv <= ex_badv;
                end
            end
            if (ertn_flush) begin
                crmd[wb_pkg::CRMD_PLV_LSB +: 2] <= prmd[wb_pkg::CRMD_PLV_LSB +: 2];
                crmd[wb_pkg::CRMD_IE_BIT]       <= prmd[wb_pkg::CRMD_IE_BIT];
                if (estat[wb_pkg::ESTAT_ECODE_LSB +: 6] == wb_pkg::ECODE_TLBR) begin
                    crmd[wb_pkg::CRMD_DA_BIT] <= 1'b0;   // back from refill
                end
            end
            if (tlbsrch_en) begin
                if (tlbsrch_found) begin
                    tlbidx[IDXW-1:0]              <= tlbsrch_idx;
                    tlbidx[wb_pkg::TLBIDX_NE_BIT] <= 1'b0;
                end else begin
                    tlbidx[wb_pkg::TLBIDX_NE_BIT] <= 1'b1;   // no match
                end
            end
        end
    end

    always_comb begin
        case (csr_num)
            wb_pkg::CSR_CRMD:      rd_value = crmd;
            wb_pkg::CSR_PRMD:      rd_value = prmd;
            wb_pkg::CSR_ESTAT:     rd_value = estat;
            wb_pkg::CSR_ERA:       rd_value = era;
            wb_pkg::CSR_BADV:      rd_value = badv;
            wb_pkg::CSR_EENTRY:    rd_value = eentry;
            wb_pkg::CSR_TLBIDX:    rd_value = tlbidx;
            wb_pkg::CSR_TID:       rd_value = tid;
            wb_pkg::CSR_TLBRENTRY: rd_value = tlbrentry;
            default:               rd_value = 32'd0;   // unknown csr
        endcase
    end

    assign csr_rvalue = csr_re ? rd_value : 32'd0;

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire               clk,
    input  wire               we,
    input  wb_pkg::reg_addr_t waddr,
    input  wb_pkg::word_t     wdata,
    input  wb_pkg::reg_addr_t raddr1,
    input  wb_pkg::reg_addr_t raddr2,
    output wb_pkg::word_t     rdata1,
    output wb_pkg::word_t     rdata2
);

    wb_pkg::word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin   // r0 is never stored
            regs[waddr] <= wdata;
        end
    end

    // read ports
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    // one bit per tlb instruction: srch, wr, fill, rd, inv (msb first)
    typedef logic [4:0]  tlb_op_t;

    // csr numbers
    localparam csr_num_t CSR_CRMD      = 14'h0;
    localparam csr_num_t CSR_PRMD      = 14'h1;
    localparam csr_num_t CSR_ESTAT     = 14'h5;
    localparam csr_num_t CSR_ERA       = 14'h6;
    localparam csr_num_t CSR_BADV      = 14'h7;
    localparam csr_num_t CSR_EENTRY    = 14'hc;
    localparam csr_num_t CSR_TLBIDX    = 14'h10;
    localparam csr_num_t CSR_TID       = 14'h40;
    localparam csr_num_t CSR_TLBRENTRY = 14'h88;

    // exception codes
    localparam ecode_t ECODE_PIL  = 6'h1;
    localparam ecode_t ECODE_PIS  = 6'h2;
    localparam ecode_t ECODE_PIF  = 6'h3;
    localparam ecode_t ECODE_PME  = 6'h4;
    localparam ecode_t ECODE_PPI  = 6'h7;
    localparam ecode_t ECODE_ADE  = 6'h8;
    localparam ecode_t ECODE_ALE  = 6'h9;
    localparam ecode_t ECODE_TLBR = 6'h3f;   // tlb refill

    // csr field positions
    localparam int CRMD_PLV_LSB    = 0;      // two bits, same place in prmd
    localparam int CRMD_IE_BIT     = 2;
    localparam int CRMD_DA_BIT     = 3;
    localparam int ESTAT_ECODE_LSB = 16;
    localparam int ESTAT_ESUB_LSB  = 22;
    localparam int TLBIDX_NE_BIT   = 31;

endpackage

`default_nettype wire
